// File: source/fp_format_pkg.sv
// ====================================================================
// binary64 format definitions
// field widths, exponent limits and the fixed special encodings
// shared by the adder pipeline
// ====================================================================
package fp_format_pkg;

  localparam int word_w   = 64;
  localparam int exp_w    = 11;
  localparam int frac_w   = 52;
  localparam int sig_w    = 53;
  // significand plus guard, round and sticky
  localparam int ext_w    = 56;
  localparam int exp_bias = 1023;
  localparam int exp_max  = 2047;

  typedef logic [word_w-1:0] fp_word_t;

  localparam fp_word_t qnan_word    = 64'h7ff8_0000_0000_0000;
  localparam fp_word_t pos_inf_word = 64'h7ff0_0000_0000_0000;
  localparam fp_word_t neg_inf_word = 64'hfff0_0000_0000_0000;
  // sign bit left off
  localparam logic [word_w-2:0] max_finite_mag = 63'h7fef_ffff_ffff_ffff;

endpackage

// File: source/fp_ctrl_pkg.sv
// ====================================================================
// adder control definitions
// rounding mode encoding and the exception flag bundle
// ====================================================================
package fp_ctrl_pkg;

  typedef enum logic [1:0] {
    rnd_trunc = 2'd0,
    rnd_even  = 2'd1,
    rnd_plus  = 2'd2,
    rnd_minus = 2'd3
  } rnd_mode_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fp_flags_t;

endpackage

// File: source/fadd_renor.sv
`timescale 1ns/1ps
// ====================================================================
// adder normalizer
// two level leading one search over 8-bit groups, then a left shift
// or a one bit right shift with exponent adjust
// ====================================================================
module fadd_renor
  import fp_format_pkg::*;
(
  input  logic [ext_w:0]   sig_in,
  input  logic [exp_w:0]   exp_in,
  output logic [ext_w-1:0] sig_out,
  output logic [exp_w:0]   exp_out,
  output logic             is_zero
);

  logic [ext_w/8-1:0] grp_any;
  logic [2:0]         grp_sel;
  logic [2:0]         bit_sel;
  logic [5:0]         coarse_sh;
  logic [5:0]         lz;
  logic [ext_w-1:0]   coarse;
  logic [ext_w-1:0]   fine;

  // highest nonzero group
  always_comb begin
    grp_sel = '0;
    for (int g = 0; g < ext_w / 8; g++) begin
      grp_any[g] = |sig_in[8*g +: 8];
      if (grp_any[g]) begin
        grp_sel = g[2:0];
      end
    end
  end

  assign coarse_sh = {3'(ext_w / 8 - 1) - grp_sel, 3'b000};
  assign coarse    = sig_in[ext_w-1:0] << coarse_sh;

  // leading one now sits in the top byte
  always_comb begin
    bit_sel = '0;
    for (int b = 0; b < 8; b++) begin
      if (coarse[ext_w-8+b]) begin
        bit_sel = b[2:0];
      end
    end
  end

  assign fine    = coarse << (3'd7 - bit_sel);
  assign lz      = coarse_sh + {3'b000, 3'd7 - bit_sel};
  assign is_zero = (sig_in == '0);

  always_comb begin
    if (sig_in[ext_w]) begin
      sig_out = {sig_in[ext_w:2], sig_in[1] | sig_in[0]};
      exp_out = exp_in + 1'b1;
    end else if (is_zero) begin
      sig_out = '0;
      exp_out = '0;
    end else begin
      sig_out = fine;
      exp_out = exp_in - {{(exp_w-5){1'b0}}, lz};
    end
  end

endmodule

// File: source/fadd_special.sv
`timescale 1ns/1ps
// ====================================================================
// special operand handling for the adder
// classifies zero, infinity and NaN inputs and registers the result
// that replaces the arithmetic path, with the invalid flag
// ====================================================================
module fadd_special
  import fp_format_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  fp_word_t op_a,
  input  fp_word_t op_b,
  input  logic     sub,
  output logic     special_hit,
  output fp_word_t special_word,
  output logic     special_invalid
);

  logic     sign_a, sign_b;
  logic     zero_a, inf_a, qnan_a, snan_a;
  logic     zero_b, inf_b, qnan_b, snan_b;
  logic     nan_any;
  logic     cls_nan, cls_inf_inv, cls_inf, cls_zz, cls_pass;
  fp_word_t word_d;

  // returns {zero, inf, qnan, snan}
  // a zero exponent counts as zero
  function automatic logic [3:0] classify(input fp_word_t w);
    logic exp_zero;
    logic exp_ones;
    logic frac_nz;
    exp_zero = (w[word_w-2:frac_w] == '0);
    exp_ones = (w[word_w-2:frac_w] == exp_max);
    frac_nz  = |w[frac_w-1:0];
    return {exp_zero, exp_ones & ~frac_nz, exp_ones & frac_nz & w[frac_w-1],
            exp_ones & frac_nz & ~w[frac_w-1]};
  endfunction

  assign {zero_a, inf_a, qnan_a, snan_a} = classify(op_a);
  assign {zero_b, inf_b, qnan_b, snan_b} = classify(op_b);
  assign sign_a  = op_a[word_w-1];
  assign sign_b  = op_b[word_w-1] ^ sub;
  assign nan_any = qnan_a | snan_a | qnan_b | snan_b;

  assign cls_nan     = nan_any;
  assign cls_inf_inv = ~nan_any & inf_a & inf_b & (sign_a ^ sign_b);
  assign cls_inf     = ~nan_any & ~cls_inf_inv & (inf_a | inf_b);
  assign cls_zz      = zero_a & zero_b;
  assign cls_pass    = (zero_a ^ zero_b) & ~nan_any & ~inf_a & ~inf_b;

  always_comb begin
    if (cls_nan || cls_inf_inv) begin
      word_d = qnan_word;
    end else if (cls_inf) begin
      word_d = (inf_a ? sign_a : sign_b) ? neg_inf_word : pos_inf_word;
    end else if (cls_zz) begin
      word_d = {sign_a & sign_b, {(word_w-1){1'b0}}};
    end else if (zero_a) begin
      word_d = {sign_b, op_b[word_w-2:0]};
    end else begin
      word_d = op_a;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      special_hit     <= 1'b0;
      special_invalid <= 1'b0;
    end else begin
      special_hit     <= cls_nan | cls_inf_inv | cls_inf | cls_zz | cls_pass;
      special_invalid <= snan_a | snan_b | cls_inf_inv;
    end
  end

  always_ff @(posedge clk) begin
    special_word <= word_d;
  end

  a_one_class: assert property (@(posedge clk) disable iff (rst)
    $onehot0({cls_nan, cls_inf_inv, cls_inf, cls_zz, cls_pass}));

endmodule

// File: source/fadd_operand_align.sv
`timescale 1ns/1ps
// ====================================================================
// adder stage one, operand alignment
// orders the operands by magnitude, resolves the result sign and
// shifts the smaller significand right with guard, round and sticky
// ====================================================================
module fadd_operand_align
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  input  fp_word_t         op_a,
  input  fp_word_t         op_b,
  input  logic             sub,
  input  rnd_mode_t        rmode,
  output logic             s1_valid,
  output logic [exp_w-1:0] s1_exp,
  output logic             s1_sign,
  output logic             s1_eff_sub,
  output logic [sig_w-1:0] s1_sig_big,
  output logic [ext_w-1:0] s1_sig_small,
  output rnd_mode_t        s1_rmode
);

  logic [exp_w-1:0] exp_a, exp_b;
  logic [exp_w-1:0] exp_big, exp_small, exp_diff;
  logic [sig_w-1:0] sig_a, sig_b, sig_big, sig_small;
  logic             sign_a, sign_b, a_big, mag_eq, eff_sub, sign_res;
  logic [ext_w-1:0] small_ext, small_shr, lost_mask, small_aligned;
  logic             sticky;

  assign exp_a = op_a[word_w-2:frac_w];
  assign exp_b = op_b[word_w-2:frac_w];
  // denormals are read as zero
  assign sig_a = (exp_a != '0) ? {1'b1, op_a[frac_w-1:0]} : '0;
  assign sig_b = (exp_b != '0) ? {1'b1, op_b[frac_w-1:0]} : '0;

  assign sign_a  = op_a[word_w-1];
  assign sign_b  = op_b[word_w-1] ^ sub;
  assign eff_sub = sign_a ^ sign_b;

  // exponent and fraction compare as one unsigned field
  assign a_big  = op_a[word_w-2:0] >= op_b[word_w-2:0];
  assign mag_eq = op_a[word_w-2:0] == op_b[word_w-2:0];

  assign exp_big   = a_big ? exp_a : exp_b;
  assign exp_small = a_big ? exp_b : exp_a;
  assign sig_big   = a_big ? sig_a : sig_b;
  assign sig_small = a_big ? sig_b : sig_a;
  assign exp_diff  = exp_big - exp_small;

  // x - x gives +0 except when rounding toward minus
  assign sign_res = (mag_eq && eff_sub) ? (rmode == rnd_minus) : (a_big ? sign_a : sign_b);

  assign small_ext = {sig_small, 3'b000};
  assign small_shr = small_ext >> exp_diff;
  assign lost_mask = ~({ext_w{1'b1}} << exp_diff);
  assign sticky    = |(small_ext & lost_mask);

  assign small_aligned = (exp_diff >= ext_w) ? {{(ext_w-1){1'b0}}, |sig_small}
                                             : {small_shr[ext_w-1:1], small_shr[0] | sticky};

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_exp       <= exp_big;
    s1_sign      <= sign_res;
    s1_eff_sub   <= eff_sub;
    s1_sig_big   <= sig_big;
    s1_sig_small <= small_aligned;
    s1_rmode     <= rmode;
  end

  // aligned operand never outgrows the larger one
  a_small_fits: assert property (@(posedge clk) disable iff (rst)
    s1_valid |-> (s1_sig_small <= {s1_sig_big, 3'b000}));

endmodule

// File: source/fadd_round.sv
`timescale 1ns/1ps
// ====================================================================
// adder stage two
// significand add, normalize, round, range check and the merge with
// the special case result into the output register
// ====================================================================
module fadd_round
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             s1_valid,
  input  logic [exp_w-1:0] s1_exp,
  input  logic             s1_sign,
  input  logic             s1_eff_sub,
  input  logic [sig_w-1:0] s1_sig_big,
  input  logic [ext_w-1:0] s1_sig_small,
  input  rnd_mode_t        s1_rmode,
  input  logic             special_hit,
  input  fp_word_t         special_word,
  input  logic             special_invalid,
  output logic             out_valid,
  output fp_word_t         result,
  output fp_flags_t        flags
);

  logic [ext_w:0]   sum;
  logic [ext_w-1:0] norm_sig;
  logic [exp_w:0]   norm_exp;
  logic             norm_zero;
  logic             lost;
  logic             rnd_inc;
  logic [sig_w:0]   rnd_sig;
  logic [exp_w+1:0] rnd_exp;
  logic             ovf, unf, to_zero;
  fp_word_t         arith_word;
  fp_flags_t        arith_flags;

  assign sum = s1_eff_sub ? {1'b0, s1_sig_big, 3'b000} - {1'b0, s1_sig_small}
                          : {1'b0, s1_sig_big, 3'b000} + {1'b0, s1_sig_small};

  fadd_renor u_renor (
    .sig_in  (sum),
    .exp_in  ({1'b0, s1_exp}),
    .sig_out (norm_sig),
    .exp_out (norm_exp),
    .is_zero (norm_zero)
  );

  // guard, round, sticky in the low three bits
  assign lost = |norm_sig[2:0];

  always_comb begin
    case (s1_rmode)
      rnd_even:  rnd_inc = norm_sig[2] & (norm_sig[1] | norm_sig[0] | norm_sig[3]);
      rnd_plus:  rnd_inc = ~s1_sign & lost;
      rnd_minus: rnd_inc = s1_sign & lost;
      default:   rnd_inc = 1'b0;
    endcase
  end

  assign rnd_sig = {1'b0, norm_sig[ext_w-1:3]} + {{sig_w{1'b0}}, rnd_inc};
  // carry leaves 1.000..0 in the fraction bits so only the exponent moves
  assign rnd_exp = {norm_exp[exp_w], norm_exp} + {{(exp_w+1){1'b0}}, rnd_sig[sig_w]};

  assign ovf     = ~rnd_exp[exp_w+1] && (rnd_exp[exp_w:0] >= exp_max);
  assign unf     = rnd_exp[exp_w+1] || (rnd_exp == '0);
  assign to_zero = (s1_rmode == rnd_trunc) || (s1_rmode == rnd_plus && s1_sign) ||
                   (s1_rmode == rnd_minus && !s1_sign);

  always_comb begin
    arith_flags = '0;
    if (norm_zero || unf) begin
      arith_word = {s1_sign, {(word_w-1){1'b0}}};
    end else if (ovf) begin
      arith_word = to_zero ? {s1_sign, max_finite_mag} : (s1_sign ? neg_inf_word : pos_inf_word);
      arith_flags.overflow = 1'b1;
      arith_flags.inexact  = 1'b1;
    end else begin
      arith_word = {s1_sign, rnd_exp[exp_w-1:0], rnd_sig[frac_w-1:0]};
      arith_flags.inexact = lost;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else begin
      out_valid <= s1_valid;
      if (s1_valid && special_hit) begin
        result <= special_word;
        flags  <= '{invalid: special_invalid, default: 1'b0};
      end else if (s1_valid) begin
        result <= arith_word;
        flags  <= arith_flags;
      end
    end
  end

  a_quiet_after_rst: assert property (@(posedge clk) rst |=> !out_valid);

endmodule

// File: source/fadd.sv
`timescale 1ns/1ps
// ====================================================================
// binary64 add/subtract unit
// two stage pipeline, one operation per cycle, fixed latency of two
// ====================================================================
module fadd
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  fp_word_t  op_a,
  input  fp_word_t  op_b,
  input  logic      sub,
  input  rnd_mode_t rmode,
  output logic      out_valid,
  output fp_word_t  result,
  output fp_flags_t flags
);

  logic             s1_valid;
  logic [exp_w-1:0] s1_exp;
  logic             s1_sign;
  logic             s1_eff_sub;
  logic [sig_w-1:0] s1_sig_big;
  logic [ext_w-1:0] s1_sig_small;
  rnd_mode_t        s1_rmode;
  logic             special_hit;
  fp_word_t         special_word;
  logic             special_invalid;

  fadd_special u_special (
    .clk             (clk),
    .rst             (rst),
    .op_a            (op_a),
    .op_b            (op_b),
    .sub             (sub),
    .special_hit     (special_hit),
    .special_word    (special_word),
    .special_invalid (special_invalid)
  );

  fadd_operand_align u_align (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .op_a         (op_a),
    .op_b         (op_b),
    .sub          (sub),
    .rmode        (rmode),
    .s1_valid     (s1_valid),
    .s1_exp       (s1_exp),
    .s1_sign      (s1_sign),
    .s1_eff_sub   (s1_eff_sub),
    .s1_sig_big   (s1_sig_big),
    .s1_sig_small (s1_sig_small),
    .s1_rmode     (s1_rmode)
  );

  fadd_round u_round (
    .clk             (clk),
    .rst             (rst),
    .s1_valid        (s1_valid),
    .s1_exp          (s1_exp),
    .s1_sign         (s1_sign),
    .s1_eff_sub      (s1_eff_sub),
    .s1_sig_big      (s1_sig_big),
    .s1_sig_small    (s1_sig_small),
    .s1_rmode        (s1_rmode),
    .special_hit     (special_hit),
    .special_word    (special_word),
    .special_invalid (special_invalid),
    .out_valid       (out_valid),
    .result          (result),
    .flags           (flags)
  );

endmodule

// File: bench/fadd_checker.sv
`timescale 1ns/1ps
// ====================================================================
// adder output checker
// tracks issued operations, compares each output against the queued
// expected word and flags, and checks the fixed two cycle latency
// ====================================================================
module fadd_checker
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      in_valid,
  input logic      out_valid,
  input fp_word_t  result,
  input fp_flags_t flags
);

  localparam int latency = 2;

  fp_word_t  exp_result_q[$];
  fp_flags_t exp_flags_q[$];
  int        issue_q[$];
  int        cycle = 0;
  int        value_errors = 0;
  int        protocol_errors = 0;
  int        checked = 0;

  task automatic expect_result(input fp_word_t r, input fp_flags_t f);
    exp_result_q.push_back(r);
    exp_flags_q.push_back(f);
  endtask

  function automatic int pending();
    return exp_result_q.size();
  endfunction

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin : watch
    fp_word_t  want_result;
    fp_flags_t want_flags;
    int        issued;
    cycle = cycle + 1;
    if (rst) begin
      if (out_valid !== 1'b0) begin
        protocol_errors++;
        $display("out_valid is not low during reset at time %0t", $time);
      end
    end else begin
      if (in_valid === 1'b1) begin
        issue_q.push_back(cycle);
      end
      if (out_valid === 1'b1) begin
        if (exp_result_q.size() == 0) begin
          protocol_errors++;
          $display("out_valid at time %0t with no expected result pending", $time);
        end else begin
          want_result = exp_result_q.pop_front();
          want_flags  = exp_flags_q.pop_front();
          checked++;
          if (result !== want_result) begin
            value_errors++;
            $display("ERROR time %0t result: got %h, expected %h",
                     $time, result, want_result);
          end
          if (flags !== want_flags) begin
            value_errors++;
            $display("ERROR time %0t flags: got %b, expected %b",
                     $time, flags, want_flags);
          end
        end
        if (issue_q.size() == 0) begin
          protocol_errors++;
          $display("out_valid at time %0t has no matching input", $time);
        end else begin
          issued = issue_q.pop_front();
          if (cycle - issued != latency) begin
            protocol_errors++;
            $display("output at time %0t came %0d cycles after its input instead of %0d",
                     $time, cycle - issued, latency);
          end
        end
      end else if (out_valid !== 1'b0) begin
        protocol_errors++;
        $display("out_valid is unknown at time %0t", $time);
      end
    end
  end

endmodule

// File: bench/fadd_tb.sv
`timescale 1ns/1ps
// ====================================================================
// adder testbench
// clock and reset, vectors from the stimulus file with random idle
// gaps, dut and checker instances, final report
// ====================================================================
module fadd_tb
  import fp_format_pkg::*;
  import fp_ctrl_pkg::*;
();

  localparam int clk_period  = 40;
  localparam int drive_delay = 2;
  localparam int max_vectors = 64;
  localparam int rec_w       = 6;
  localparam int drain_limit = 50;

  logic      clk;
  logic      rst;
  logic      in_valid;
  fp_word_t  op_a;
  fp_word_t  op_b;
  logic      sub;
  rnd_mode_t rmode;
  logic      out_valid;
  fp_word_t  result;
  fp_flags_t flags;

  // word 0 holds the vector count and six words per vector follow
  logic [word_w-1:0] stim_mem [0:rec_w*max_vectors];
  int                num_vectors;
  logic              timed_out;

  fadd dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .sub       (sub),
    .rmode     (rmode),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  fadd_checker chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // called 2 ns after an edge and returns 2 ns after the next one
  task automatic apply_vector(input int idx);
    int base;
    base     = 1 + rec_w * idx;
    op_a     = stim_mem[base];
    op_b     = stim_mem[base+1];
    sub      = stim_mem[base+2][0];
    rmode    = rnd_mode_t'(stim_mem[base+3][1:0]);
    in_valid = 1'b1;
    chk.expect_result(stim_mem[base+4], fp_flags_t'(stim_mem[base+5][2:0]));
    @(posedge clk);
    #drive_delay;
    in_valid = 1'b0;
  endtask

  task automatic run_vectors();
    int gap;
    int wait_cycles;
    for (int i = 0; i < num_vectors; i++) begin
      apply_vector(i);
      // first vectors go back to back
      gap = (i < 8) ? 0 : int'($urandom % 3);
      repeat (gap) begin
        @(posedge clk);
        #drive_delay;
      end
    end
    wait_cycles = 0;
    while (chk.pending() != 0 && wait_cycles < drain_limit) begin
      @(posedge clk);
      wait_cycles++;
    end
    timed_out = (chk.pending() != 0);
    if (timed_out) begin
      $display("timed out with %0d results still outstanding", chk.pending());
    end
    // catch any stray output
    repeat (4) @(posedge clk);
  endtask

  initial begin
    void'($urandom(43));
    rst       = 1'b1;
    in_valid  = 1'b0;
    op_a      = '0;
    op_b      = '0;
    sub       = 1'b0;
    rmode     = rnd_trunc;
    timed_out = 1'b0;
    $readmemh("bench/fadd_stimulus.txt", stim_mem);
    num_vectors = $isunknown(stim_mem[0]) ? 0 : int'(stim_mem[0]);
    if (num_vectors < 1 || num_vectors > max_vectors) begin
      $display("stimulus file gave no usable vector count");
      $display("Testbench failed");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      #drive_delay;
      rst = 1'b0;
      run_vectors();
      $display("vectors %0d, checked %0d, value errors %0d, protocol errors %0d",
               num_vectors, chk.checked, chk.value_errors, chk.protocol_errors);
      if (timed_out || chk.value_errors != 0 || chk.protocol_errors != 0 ||
          chk.checked != num_vectors) begin
        $display("Testbench failed");
      end else begin
        $display("Testbench passed");
      end
      $finish;
    end
  end

endmodule

// File: bench/fadd_stimulus.txt
// columns: op_a op_b sub rmode expected_result expected_flags, all hex
// rmode 0 trunc 1 even 2 plus 3 minus; flags 4 invalid 2 overflow 1 inexact
24
// normal adds and subtracts, nearest even
3ff0000000000000 4000000000000000 0 1 4008000000000000 0
4008000000000000 bff0000000000000 0 1 4000000000000000 0
3ff0000000000000 3fe0000000000000 1 1 3fe0000000000000 0
3ff0000000000000 3ff0000000000000 0 1 4000000000000000 0
c000000000000000 3fe0000000000000 0 1 bff8000000000000 0
3ff0000000000000 3c30000000000000 0 1 3ff0000000000000 1
3ff0000000000000 3c30000000000000 1 1 3ff0000000000000 1
3ff0000000000000 3f50000000000000 0 1 3ff0040000000000 0
// 1 + 0.75 ulp and its negative under all four modes, then two ties
3ff0000000000000 3ca8000000000000 0 0 3ff0000000000000 1
3ff0000000000000 3ca8000000000000 0 1 3ff0000000000001 1
3ff0000000000000 3ca8000000000000 0 2 3ff0000000000001 1
3ff0000000000000 3ca8000000000000 0 3 3ff0000000000000 1
bff0000000000000 3ca8000000000000 1 0 bff0000000000000 1
bff0000000000000 3ca8000000000000 1 1 bff0000000000001 1
bff0000000000000 3ca8000000000000 1 2 bff0000000000000 1
bff0000000000000 3ca8000000000000 1 3 bff0000000000001 1
3ff0000000000000 3ca0000000000000 0 1 3ff0000000000000 1
3ff0000000000001 3ca0000000000000 0 1 3ff0000000000002 1
// NaN, infinity and zero operands
7ff8000000000000 3ff0000000000000 0 1 7ff8000000000000 0
3ff0000000000000 fff8000000000001 0 1 7ff8000000000000 0
7ff0000000000001 3ff0000000000000 0 1 7ff8000000000000 4
7ff0000000000000 7ff0000000000000 1 1 7ff8000000000000 4
7ff0000000000000 3ff0000000000000 0 1 7ff0000000000000 0
4000000000000000 fff0000000000000 0 1 fff0000000000000 0
3ff0000000000000 7ff0000000000000 1 1 fff0000000000000 0
0000000000000000 3ff8000000000000 0 1 3ff8000000000000 0
0000000000000000 3ff8000000000000 1 1 bff8000000000000 0
8000000000000000 8000000000000000 0 1 8000000000000000 0
0000000000000001 3ff0000000000000 0 1 3ff0000000000000 0
// overflow
7fefffffffffffff 7fefffffffffffff 0 1 7ff0000000000000 3
7fefffffffffffff 7fefffffffffffff 0 0 7fefffffffffffff 3
ffefffffffffffff ffefffffffffffff 0 2 ffefffffffffffff 3
ffefffffffffffff 7fefffffffffffff 1 3 fff0000000000000 3
// exact cancellation
4008000000000000 4008000000000000 1 1 0000000000000000 0
4008000000000000 4008000000000000 1 3 8000000000000000 0
bff0000000000000 3ff0000000000000 0 3 8000000000000000 0

// File: vlog.f
source/fp_format_pkg.sv
source/fp_ctrl_pkg.sv
source/fadd_renor.sv
source/fadd_special.sv
source/fadd_operand_align.sv
source/fadd_round.sv
source/fadd.sv
bench/fadd_checker.sv
bench/fadd_tb.sv

// File: Bender.yml
package:
  name: fadd

sources:
  - source/fp_format_pkg.sv
  - source/fp_ctrl_pkg.sv
  - source/fadd_renor.sv
  - source/fadd_special.sv
  - source/fadd_operand_align.sv
  - source/fadd_round.sv
  - source/fadd.sv
  - target: test
    files:
      - bench/fadd_checker.sv
      - bench/fadd_tb.sv
